// ==== src/l1_cache_pkg.sv ====
/*
 * shared types and constants for the direct-mapped L1 cache
 */
package l1_cache_pkg;

    localparam int WORD_BYTES = 4; // bytes per bus word

    typedef logic [31:0] word_t;           // data and address word
    typedef logic [WORD_BYTES-1:0] sel_t;  // one bit per byte lane

    // controller states
    typedef enum logic [2:0] {
        IDLE,
        WRITEBACK,  // dirty victim going out before a fill
        FILL,       // line coming in word by word
        PASS,       // single beat to the uncached region
        FLUSH_SCAN, // walking the sets
        FLUSH_WB    // writing back one dirty set
    } cache_state_t;

    // operation handed to the memory bus master
    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_FILL,
        MEM_WRITEBACK,
        MEM_PASS
    } mem_op_t;

endpackage

// ==== src/tag_store.sv ====
/*
 * tag store of the L1 cache
 * valid, dirty and tag per set, address decode and hit detection
 */
`timescale 1ns/1ns

module tag_store import l1_cache_pkg::*; #(
    parameter int    CACHE_SIZE          = 1024,
    parameter int    BLOCK_SIZE          = 2,
    parameter word_t NONCACHE_START_ADDR = 32'h8000_0000,
    localparam int   N_SETS              = CACHE_SIZE / (BLOCK_SIZE * WORD_BYTES),
    localparam int   SET_BITS            = $clog2(N_SETS),
    localparam int   OFF_BITS            = $clog2(BLOCK_SIZE),
    localparam int   TAG_BITS            = 32 - SET_BITS - OFF_BITS - 2
) (
    input  logic                CLK,
    input  logic                nRST,
    input  word_t               cpu_adr,
    input  logic                scan_mode,
    input  logic [SET_BITS-1:0] scan_set,
    input  logic                fill_commit,
    input  logic                mark_dirty,
    input  logic                mark_clean,
    output logic                hit,
    output logic                uncached,
    output logic                victim_dirty,
    output logic [TAG_BITS-1:0] victim_tag,
    output logic [SET_BITS-1:0] sel_set,
    output logic [TAG_BITS-1:0] req_tag,
    output logic [OFF_BITS-1:0] word_off
);
    // processor address split into cache fields
    typedef struct packed {
        logic [TAG_BITS-1:0] tag;
        logic [SET_BITS-1:0] set;
        logic [OFF_BITS-1:0] off;  // word within line
        logic [1:0]          lane; // byte within word
    } addr_fields_t;

    typedef union packed {
        word_t        word;
        addr_fields_t f;
    } cpu_addr_t;

    cpu_addr_t           req;
    logic [N_SETS-1:0]   valid;
    logic [N_SETS-1:0]   dirty;
    logic [TAG_BITS-1:0] tags [N_SETS];

    assign req.word = cpu_adr;
    assign req_tag  = req.f.tag;
    assign word_off = req.f.off;
    assign uncached = req.word >= NONCACHE_START_ADDR; // mmio region bypasses the arrays

    // flush walks its own set, otherwise the request picks it
    assign sel_set      = scan_mode ? scan_set : req.f.set;
    assign victim_tag   = tags[sel_set];
    assign victim_dirty = valid[sel_set] && dirty[sel_set];
    assign hit          = valid[sel_set] && (tags[sel_set] == req.f.tag) && !uncached;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid <= '0; // every line starts invalid and clean
            dirty <= '0;
        end else begin
            if (fill_commit) begin
                valid[sel_set] <= 1'b1;
                dirty[sel_set] <= 1'b0; // fresh line matches memory
            end else if (mark_dirty) begin
                dirty[sel_set] <= 1'b1;
            end else if (mark_clean) begin
                dirty[sel_set] <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (fill_commit) begin
            tags[sel_set] <= req.f.tag;
        end
    end

endmodule

// ==== src/data_store.sv ====
/*
 * line data array of the L1 cache
 * byte-lane merge for processor writes, whole words for fills
 */
`timescale 1ns/1ns

module data_store import l1_cache_pkg::*; #(
    parameter int  CACHE_SIZE = 1024,
    parameter int  BLOCK_SIZE = 2,
    localparam int N_SETS     = CACHE_SIZE / (BLOCK_SIZE * WORD_BYTES),
    localparam int SET_BITS   = $clog2(N_SETS),
    localparam int OFF_BITS   = $clog2(BLOCK_SIZE)
) (
    input  logic                CLK,
    input  logic                nRST,
    input  logic [SET_BITS-1:0] sel_set,
    input  logic [OFF_BITS-1:0] word_off,
    input  logic                cpu_we_hit,
    input  sel_t                cpu_sel,
    input  word_t               cpu_dat_w,
    input  logic                fill_we,
    input  logic [OFF_BITS-1:0] fill_word,
    input  word_t               fill_data,
    input  logic [OFF_BITS-1:0] rd_word,
    output word_t               rd_data
);
    word_t lines [N_SETS][BLOCK_SIZE];
    word_t merged; // cached word with the written lanes swapped in

    // one read port serves hit data and write-back beats
    assign rd_data = lines[sel_set][rd_word];

    always_comb begin
        merged = lines[sel_set][word_off];
        for (int b = 0; b < WORD_BYTES; b++) begin
            if (cpu_sel[b]) begin
                merged[8*b +: 8] = cpu_dat_w[8*b +: 8];
            end
        end
    end

    // writes held off while nRST is low
    always_ff @(posedge CLK) begin
        if (nRST) begin
            if (fill_we) begin
                lines[sel_set][fill_word] <= fill_data; // whole word from memory
            end else if (cpu_we_hit) begin
                lines[sel_set][word_off] <= merged;
            end
        end
    end

endmodule

// ==== src/mem_bus_master.sv ====
/*
 * memory-side Wishbone classic master
 * runs line fills, line write-backs and single pass-through beats
 */
`timescale 1ns/1ns

module mem_bus_master import l1_cache_pkg::*; #(
    parameter int  CACHE_SIZE = 1024,
    parameter int  BLOCK_SIZE = 2,
    localparam int N_SETS     = CACHE_SIZE / (BLOCK_SIZE * WORD_BYTES),
    localparam int SET_BITS   = $clog2(N_SETS),
    localparam int OFF_BITS   = $clog2(BLOCK_SIZE),
    localparam int TAG_BITS   = 32 - SET_BITS - OFF_BITS - 2
) (
    input  logic                CLK,
    input  logic                nRST,
    input  mem_op_t             mem_op,
    input  logic                op_start,
    input  logic [TAG_BITS-1:0] line_tag,
    input  logic [SET_BITS-1:0] line_set,
    input  logic                cpu_we,
    input  sel_t                cpu_sel,
    input  word_t               cpu_adr,
    input  word_t               cpu_dat_w,
    input  word_t               rd_data,
    output logic [OFF_BITS-1:0] rd_word,
    output logic                fill_we,
    output logic [OFF_BITS-1:0] fill_word,
    output word_t               fill_data,
    output logic                op_done,
    output word_t               pass_data,
    output logic                mem_cyc,
    output logic                mem_stb,
    output logic                mem_we,
    output sel_t                mem_sel,
    output word_t               mem_adr,
    output word_t               mem_dat_w,
    input  word_t               mem_dat_r,
    input  logic                mem_ack
);
    logic                busy;
    mem_op_t             cur_op;    // latched at op_start
    logic [OFF_BITS-1:0] beat;      // word index within the line
    logic                is_pass;
    logic                last_beat;
    logic                beat_ack;
    word_t               lane_mask;

    assign is_pass   = cur_op == MEM_PASS;
    assign last_beat = is_pass || (beat == OFF_BITS'(BLOCK_SIZE - 1));
    assign beat_ack  = busy && mem_ack;

    // beat stays on the bus until acked, no wait states of our own
    assign mem_cyc   = busy;
    assign mem_stb   = busy;
    assign mem_we    = busy && ((cur_op == MEM_WRITEBACK) || (is_pass && cpu_we));
    assign mem_sel   = is_pass ? cpu_sel : '1;
    assign mem_adr   = is_pass ? {cpu_adr[31:2], 2'b00} : {line_tag, line_set, beat, 2'b00};
    assign mem_dat_w = is_pass ? cpu_dat_w : rd_data;

    // write-back reads the line by beat, otherwise the request word
    assign rd_word = (busy && cur_op == MEM_WRITEBACK) ? beat : cpu_adr[OFF_BITS+1:2];

    assign fill_we   = beat_ack && (cur_op == MEM_FILL);
    assign fill_word = beat;
    assign fill_data = mem_dat_r;
    assign op_done   = beat_ack && last_beat; // same cycle as the final ack

    always_comb begin
        for (int b = 0; b < WORD_BYTES; b++) begin
            lane_mask[8*b +: 8] = {8{cpu_sel[b]}};
        end
    end

    // unselected lanes read as zero, controller registers this on op_done
    assign pass_data = mem_dat_r & lane_mask;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy   <= 1'b0;
            cur_op <= MEM_NONE;
            beat   <= '0;
        end else if (op_start) begin
            busy   <= mem_op != MEM_NONE; // also restarts right after a write-back
            cur_op <= mem_op;
            beat   <= '0;
        end else if (beat_ack) begin
            if (last_beat) begin
                busy   <= 1'b0;
                cur_op <= MEM_NONE;
            end else begin
                beat <= beat + 1'b1; // next word address next cycle
            end
        end
    end

endmodule

// ==== src/cache_ctrl.sv ====
/*
 * L1 cache controller
 * miss, pass-through and flush sequencing plus the processor acknowledge
 */
`timescale 1ns/1ns

module cache_ctrl import l1_cache_pkg::*; #(
    parameter int  CACHE_SIZE = 1024,
    parameter int  BLOCK_SIZE = 2,
    localparam int N_SETS     = CACHE_SIZE / (BLOCK_SIZE * WORD_BYTES),
    localparam int SET_BITS   = $clog2(N_SETS)
) (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                cpu_cyc,
    input  logic                cpu_stb,
    input  logic                cpu_we,
    input  logic                flush,
    input  logic                hit,
    input  logic                uncached,
    input  logic                victim_dirty,
    input  logic                op_done,
    input  word_t               rd_data,
    input  word_t               pass_data,
    output logic                cpu_ack,
    output word_t               cpu_dat_r,
    output logic                cpu_we_hit,
    output mem_op_t             mem_op,
    output logic                op_start,
    output logic                fill_commit,
    output logic                mark_dirty,
    output logic                mark_clean,
    output logic                scan_mode,
    output logic [SET_BITS-1:0] scan_set,
    output logic                line_tag_sel,
    output logic                flush_done
);
    cache_state_t        state;
    cache_state_t        next_state;
    logic [SET_BITS-1:0] scan_ctr;   // flush set counter
    logic                req;
    logic                hit_ack;
    logic                rd_hit;
    logic                pass_ack;
    logic                last_set;
    logic                scan_next;
    logic                flush_end;

    // request is still on the bus during the ack cycle, ignore it there
    assign req        = cpu_cyc && cpu_stb && !cpu_ack;
    assign hit_ack    = (state == IDLE) && req && hit;
    assign rd_hit     = hit_ack && !cpu_we;
    assign cpu_we_hit = hit_ack && cpu_we;  // data store merges on the ack edge
    assign mark_dirty = cpu_we_hit;
    assign pass_ack   = (state == PASS) && op_done;

    assign scan_mode    = (state == FLUSH_SCAN) || (state == FLUSH_WB);
    assign scan_set     = scan_ctr;
    assign last_set     = scan_ctr == SET_BITS'(N_SETS - 1);
    assign line_tag_sel = (state == WRITEBACK) || (state == FLUSH_WB); // victim line base

    always_comb begin
        next_state  = state;
        mem_op      = MEM_NONE;
        op_start    = 1'b0;
        fill_commit = 1'b0;
        mark_clean  = 1'b0;
        scan_next   = 1'b0;
        flush_end   = 1'b0;
        case (state)
            IDLE: begin
                if (req && uncached) begin
                    next_state = PASS;
                    mem_op     = MEM_PASS;
                    op_start   = 1'b1;
                end else if (req && !hit && victim_dirty) begin
                    next_state = WRITEBACK; // evict first
                    mem_op     = MEM_WRITEBACK;
                    op_start   = 1'b1;
                end else if (req && !hit) begin
                    next_state = FILL;
                    mem_op     = MEM_FILL;
                    op_start   = 1'b1;
                end else if (flush && !(cpu_cyc && cpu_stb)) begin
                    next_state = FLUSH_SCAN; // requests win over flush
                end
            end
            WRITEBACK: begin
                if (op_done) begin
                    next_state = FILL;
                    mem_op     = MEM_FILL;
                    op_start   = 1'b1;
                end
            end
            FILL: begin
                if (op_done) begin
                    fill_commit = 1'b1; // last word lands on this edge too
                    next_state  = IDLE; // held request then hits
                end
            end
            PASS: begin
                if (op_done) begin
                    next_state = IDLE;
                end
            end
            FLUSH_SCAN: begin
                if (victim_dirty) begin
                    next_state = FLUSH_WB;
                    mem_op     = MEM_WRITEBACK;
                    op_start   = 1'b1;
                end else if (last_set) begin
                    next_state = IDLE;
                    flush_end  = 1'b1;
                end else begin
                    scan_next = 1'b1; // clean set costs one cycle
                end
            end
            FLUSH_WB: begin
                if (op_done) begin
                    mark_clean = 1'b1;
                    if (last_set) begin
                        next_state = IDLE;
                        flush_end  = 1'b1;
                    end else begin
                        next_state = FLUSH_SCAN;
                        scan_next  = 1'b1;
                    end
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state      <= IDLE;
            scan_ctr   <= '0;
            cpu_ack    <= 1'b0;
            flush_done <= 1'b0;
        end else begin
            state      <= next_state;
            cpu_ack    <= hit_ack || pass_ack; // single cycle, req masks the repeat
            flush_done <= flush_end;
            if (state == IDLE) begin
                scan_ctr <= '0;
            end else if (scan_next) begin
                scan_ctr <= scan_ctr + 1'b1;
            end
        end
    end

    // read data rides with cpu_ack
    always_ff @(posedge CLK) begin
        if (rd_hit) begin
            cpu_dat_r <= rd_data;
        end else if (pass_ack) begin
            cpu_dat_r <= pass_data;
        end
    end

endmodule

// ==== src/l1_cache.sv ====
/*
 * direct-mapped write-back L1 cache
 * Wishbone classic slave toward the processor, master toward memory
 */
`timescale 1ns/1ns

module l1_cache import l1_cache_pkg::*; #(
    parameter int    CACHE_SIZE          = 1024,           // bytes, power of 2
    parameter int    BLOCK_SIZE          = 2,              // words per line, up to 8
    parameter word_t NONCACHE_START_ADDR = 32'h8000_0000,
    localparam int   N_SETS              = CACHE_SIZE / (BLOCK_SIZE * WORD_BYTES),
    localparam int   SET_BITS            = $clog2(N_SETS),
    localparam int   OFF_BITS            = $clog2(BLOCK_SIZE),
    localparam int   TAG_BITS            = 32 - SET_BITS - OFF_BITS - 2
) (
    input  logic  CLK,
    input  logic  nRST,
    input  logic  flush,
    output logic  flush_done,
    // processor side
    input  logic  cpu_cyc,
    input  logic  cpu_stb,
    input  logic  cpu_we,
    input  sel_t  cpu_sel,
    input  word_t cpu_adr,
    input  word_t cpu_dat_w,
    output word_t cpu_dat_r,
    output logic  cpu_ack,
    // memory side
    output logic  mem_cyc,
    output logic  mem_stb,
    output logic  mem_we,
    output sel_t  mem_sel,
    output word_t mem_adr,
    output word_t mem_dat_w,
    input  word_t mem_dat_r,
    input  logic  mem_ack
);
    logic                hit, uncached, victim_dirty;
    logic [TAG_BITS-1:0] victim_tag, req_tag, line_tag;
    logic [SET_BITS-1:0] sel_set, scan_set;
    logic [OFF_BITS-1:0] word_off, rd_word, fill_word;
    logic                scan_mode, fill_commit, mark_dirty, mark_clean;
    logic                cpu_we_hit, op_start, op_done, line_tag_sel, fill_we;
    mem_op_t             mem_op;
    word_t               rd_data, fill_data, pass_data;

    // write-back goes to the victim's line, fill to the request's
    assign line_tag = line_tag_sel ? victim_tag : req_tag;

    cache_ctrl #(.CACHE_SIZE(CACHE_SIZE), .BLOCK_SIZE(BLOCK_SIZE)) u_ctrl (
        .CLK, .nRST, .cpu_cyc, .cpu_stb, .cpu_we, .flush, .hit, .uncached,
        .victim_dirty, .op_done, .rd_data, .pass_data, .cpu_ack, .cpu_dat_r,
        .cpu_we_hit, .mem_op, .op_start, .fill_commit, .mark_dirty, .mark_clean,
        .scan_mode, .scan_set, .line_tag_sel, .flush_done
    );

    tag_store #(
        .CACHE_SIZE(CACHE_SIZE),
        .BLOCK_SIZE(BLOCK_SIZE),
        .NONCACHE_START_ADDR(NONCACHE_START_ADDR)
    ) u_tags (
        .CLK, .nRST, .cpu_adr, .scan_mode, .scan_set, .fill_commit, .mark_dirty,
        .mark_clean, .hit, .uncached, .victim_dirty, .victim_tag, .sel_set,
        .req_tag, .word_off
    );

    data_store #(.CACHE_SIZE(CACHE_SIZE), .BLOCK_SIZE(BLOCK_SIZE)) u_data (
        .CLK, .nRST, .sel_set, .word_off, .cpu_we_hit, .cpu_sel, .cpu_dat_w,
        .fill_we, .fill_word, .fill_data, .rd_word, .rd_data
    );

    mem_bus_master #(.CACHE_SIZE(CACHE_SIZE), .BLOCK_SIZE(BLOCK_SIZE)) u_bus (
        .CLK, .nRST, .mem_op, .op_start, .line_tag, .line_set(sel_set), .cpu_we,
        .cpu_sel, .cpu_adr, .cpu_dat_w, .rd_data, .rd_word, .fill_we, .fill_word,
        .fill_data, .op_done, .pass_data, .mem_cyc, .mem_stb, .mem_we, .mem_sel,
        .mem_adr, .mem_dat_w, .mem_dat_r, .mem_ack
    );

endmodule

// ==== test/cache_checker.sv ====
/*
 * result checker of the L1 cache testbench
 * read data at cpu_ack, hit latency, memory contents after each flush
 */
`timescale 1ns/1ns

module cache_checker import l1_cache_pkg::*; (
    input  logic  CLK,
    input  logic  nRST,
    input  logic  cpu_cyc, cpu_stb, cpu_we, cpu_ack,
    input  sel_t  cpu_sel,
    input  word_t cpu_adr, cpu_dat_w, cpu_dat_r,
    input  logic  mem_cyc, mem_stb, mem_we, mem_ack,
    input  sel_t  mem_sel,
    input  word_t mem_adr, mem_dat_w,
    input  logic  flush_done,
    input  word_t exp_data, // read value expected for the current access
    input  logic  exp_hit,  // current access must be served as a hit
    output int    errors,
    output int    checks
);
    word_t shadow   [word_t]; // every processor write, lanes merged
    word_t mem_copy [word_t]; // what reached memory through the memory port
    word_t wadr;
    word_t old;
    int    wait_cycles;       // request cycles before the ack
    logic  done_seen;

    // untouched memory holds its own address scrambled
    function automatic word_t default_word(input word_t adr);
        return adr ^ 32'h5a5a_5a5a;
    endfunction

    function automatic word_t merge_lanes(input word_t base, input word_t wdat, input sel_t sel);
        word_t res;
        res = base;
        for (int b = 0; b < WORD_BYTES; b++) begin
            if (sel[b]) begin
                res[8*b +: 8] = wdat[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic compare_memory();
        word_t got;
        foreach (shadow[a]) begin
            got = mem_copy.exists(a) ? mem_copy[a] : default_word(a);
            checks++;
            if (got !== shadow[a]) begin
                errors++;
                $display("Fail %0t mem[%h] expected %h got %h", $time, a, shadow[a], got);
            end
        end
    endtask

    always @(posedge CLK) begin
        if (!nRST) begin
            errors      = 0;
            checks      = 0;
            wait_cycles = 0;
            done_seen   = 1'b0;
        end else begin
            if (cpu_cyc && cpu_stb && !cpu_ack) begin
                wait_cycles++;
            end
            if (cpu_ack) begin
                if (cpu_we) begin
                    wadr         = {cpu_adr[31:2], 2'b00};
                    old          = shadow.exists(wadr) ? shadow[wadr] : default_word(wadr);
                    shadow[wadr] = merge_lanes(old, cpu_dat_w, cpu_sel);
                end else begin
                    checks++;
                    if (cpu_dat_r !== exp_data) begin
                        errors++;
                        $display("Fail %0t cpu_dat_r expected %h got %h",
                                 $time, exp_data, cpu_dat_r);
                    end
                end
                if (exp_hit && wait_cycles != 1) begin
                    errors++;
                    $display("read of %h took %0d cycles where a cache hit was expected",
                             cpu_adr, wait_cycles);
                end
                wait_cycles = 0;
            end
            if (mem_cyc && mem_stb && mem_we && mem_ack) begin
                old              = mem_copy.exists(mem_adr) ? mem_copy[mem_adr]
                                                            : default_word(mem_adr);
                mem_copy[mem_adr] = merge_lanes(old, mem_dat_w, mem_sel);
            end
            if (flush_done) begin
                if (done_seen) begin
                    errors++;
                    $display("flush_done stayed high for more than one cycle");
                end else begin
                    compare_memory(); // every dirty line must be out by now
                end
            end
            done_seen = flush_done;
        end
    end

endmodule

// ==== test/l1_cache_assertions.sv ====
/*
 * Wishbone and flush protocol assertions, bound into the L1 cache top level
 */
`timescale 1ns/1ns

module l1_cache_assertions import l1_cache_pkg::*; (
    input logic  CLK,
    input logic  nRST,
    input logic  cpu_stb,
    input logic  cpu_ack,
    input logic  mem_stb,
    input logic  mem_ack,
    input word_t mem_adr,
    input logic  flush_done
);
    // slave only answers a live strobe
    ack_needs_stb: assert property (@(posedge CLK) disable iff (!nRST) cpu_ack |-> cpu_stb)
        else $error("cpu_ack raised without cpu_stb");

    // beat parked on the bus until memory takes it
    beat_held: assert property (@(posedge CLK) disable iff (!nRST)
        mem_stb && !mem_ack |=> mem_stb && $stable(mem_adr))
        else $error("mem_stb dropped or mem_adr moved before mem_ack");

    no_done_with_ack: assert property (@(posedge CLK) disable iff (!nRST)
        !(flush_done && cpu_ack))
        else $error("flush_done and cpu_ack in the same cycle");

endmodule

bind l1_cache l1_cache_assertions u_assert (
    .CLK, .nRST, .cpu_stb, .cpu_ack, .mem_stb, .mem_ack, .mem_adr, .flush_done
);

// ==== test/tb_l1_cache.sv ====
/*
 * testbench of the direct-mapped L1 cache
 * file driven processor accesses, memory model with random wait states
 */
`timescale 1ns/1ns

module tb_l1_cache import l1_cache_pkg::*; ();

    localparam int         CLK_HALF      = 50;
    localparam int         CYCLES_PER_OP = 40; // watchdog budget per stimulus line
    localparam string      STIM_FILE     = "test/l1_cache_stim.txt";
    localparam logic [3:0] OP_WRITE      = 4'h1;
    localparam logic [3:0] OP_FLUSH      = 4'h2;
    localparam logic [3:0] OP_HIT_READ   = 4'h3; // read that must hit

    logic  CLK = 1'b0;
    logic  nRST;
    logic  flush, flush_done;
    logic  cpu_cyc, cpu_stb, cpu_we, cpu_ack;
    sel_t  cpu_sel, mem_sel;
    word_t cpu_adr, cpu_dat_w, cpu_dat_r;
    logic  mem_cyc, mem_stb, mem_we;
    logic  mem_ack = 1'b0;
    word_t mem_adr, mem_dat_w;
    word_t mem_dat_r = '0;
    word_t exp_data;
    logic  exp_hit;
    int    errors, checks;

    logic [3:0]  op_q [$];
    word_t       adr_q [$];
    sel_t        sel_q [$];
    word_t       dat_q [$];
    word_t       exp_q [$];
    logic        ops_loaded = 1'b0;
    word_t       mem_words [word_t]; // memory model keyed by word aligned byte address
    logic [31:0] lfsr = 32'hdbdb;
    int unsigned beat_delay;
    logic        beat_pending;       // wait states already drawn for this beat

    always #CLK_HALF CLK = ~CLK;

    l1_cache u_dut (.*);

    cache_checker u_check (.*);

    // fibonacci lfsr stepped once per bit handed out
    function automatic int unsigned random_bits(input int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = (v << 1) | lfsr[0];
        end
        return v;
    endfunction

    task automatic serve_beat();
        word_t cur;
        cur = mem_words.exists(mem_adr) ? mem_words[mem_adr] : (mem_adr ^ 32'h5a5a_5a5a);
        if (mem_we) begin
            for (int b = 0; b < WORD_BYTES; b++) begin
                if (mem_sel[b]) begin
                    cur[8*b +: 8] = mem_dat_w[8*b +: 8];
                end
            end
            mem_words[mem_adr] = cur;
        end
        mem_dat_r = cur;
        mem_ack   = 1'b1;
    endtask

    // memory slave adding 0 to 3 wait cycles per beat
    always @(negedge CLK) begin
        if (!nRST) begin
            mem_ack      = 1'b0;
            beat_pending = 1'b0;
        end else if (mem_ack) begin
            mem_ack = 1'b0; // taken on the last rising edge
        end else if (mem_cyc && mem_stb) begin
            if (!beat_pending) begin
                beat_delay   = random_bits(2);
                beat_pending = 1'b1;
            end
            if (beat_delay == 0) begin
                serve_beat();
                beat_pending = 1'b0;
            end else begin
                beat_delay = beat_delay - 1;
            end
        end
    end

    task automatic load_stimulus(output bit ok);
        int          fd;
        int          cnt;
        string       line;
        bit          bad;
        logic [31:0] f_op, f_adr, f_sel, f_dat, f_exp;
        ok  = 1'b0;
        bad = 1'b0;
        fd  = $fopen(STIM_FILE, "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                cnt  = $fgets(line, fd);
                if (line.len() > 1 && line.getc(0) != "#") begin // skip blanks and comments
                    cnt = $sscanf(line, "%h %h %h %h %h", f_op, f_adr, f_sel, f_dat, f_exp);
                    if (cnt != 5 || f_op > 32'h3) begin
                        bad = 1'b1;
                    end else begin
                        op_q.push_back(f_op[3:0]);
                        adr_q.push_back(f_adr);
                        sel_q.push_back(f_sel[3:0]);
                        dat_q.push_back(f_dat);
                        exp_q.push_back(f_exp);
                    end
                end
            end
            $fclose(fd);
            ok = !bad && op_q.size() > 0;
        end
    endtask

    task automatic cpu_access(input logic we, input logic must_hit, input word_t adr,
                              input sel_t sel, input word_t wdat, input word_t expd);
        @(negedge CLK);
        cpu_cyc   = 1'b1;
        cpu_stb   = 1'b1;
        cpu_we    = we;
        cpu_sel   = sel;
        cpu_adr   = adr;
        cpu_dat_w = wdat;
        exp_data  = expd;
        exp_hit   = must_hit;
        do begin
            @(negedge CLK);
        end while (!cpu_ack);
        @(negedge CLK); // request held through the ack cycle
        cpu_cyc = 1'b0;
        cpu_stb = 1'b0;
        cpu_we  = 1'b0;
        exp_hit = 1'b0;
    endtask

    task automatic flush_cache();
        @(negedge CLK);
        flush = 1'b1; // bus idle so the controller takes it
        @(negedge CLK);
        flush = 1'b0;
        do begin
            @(negedge CLK);
        end while (!flush_done);
    endtask

    task automatic run_tests();
        for (int i = 0; i < op_q.size(); i++) begin
            if (op_q[i] == OP_FLUSH) begin
                flush_cache();
            end else begin
                cpu_access(op_q[i] == OP_WRITE, op_q[i] == OP_HIT_READ, adr_q[i], sel_q[i],
                           dat_q[i], exp_q[i]);
            end
        end
    endtask

    initial begin
        bit ok;
        nRST      = 1'b0;
        flush     = 1'b0;
        cpu_cyc   = 1'b0;
        cpu_stb   = 1'b0;
        cpu_we    = 1'b0;
        cpu_sel   = '0;
        cpu_adr   = '0;
        cpu_dat_w = '0;
        exp_data  = '0;
        exp_hit   = 1'b0;
        load_stimulus(ok);
        if (!ok) begin
            $display("stimulus file %s is missing, empty or malformed", STIM_FILE);
            $display("TEST FAIL");
            $finish;
        end else begin
            ops_loaded = 1'b1;
            repeat (2) @(negedge CLK);
            nRST = 1'b1;
            run_tests();
            repeat (2) @(negedge CLK); // checker still samples the last edges
            $display("%0d errors in %0d checks", errors, checks);
            if (errors == 0) begin
                $display("TEST PASS");
            end else begin
                $display("TEST FAIL");
            end
            $finish;
        end
    end

    // watchdog sized from the stimulus length
    initial begin
        wait (ops_loaded);
        repeat (op_q.size() * CYCLES_PER_OP) @(posedge CLK);
        $display("watchdog expired after %0d cycles, the DUT stopped responding",
                 op_q.size() * CYCLES_PER_OP);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== sim.f ====
src/l1_cache_pkg.sv
src/tag_store.sv
src/data_store.sv
src/mem_bus_master.sv
src/cache_ctrl.sv
src/l1_cache.sv
test/cache_checker.sv
test/l1_cache_assertions.sv
test/tb_l1_cache.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the cache testbench with Verilator, run it, and judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_l1_cache -f sim.f -o sim_l1_cache \
    && ./obj_dir/sim_l1_cache > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "TEST PASS" sim.log 2>/dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== test/l1_cache_stim.txt ====
# op adr sel wdata expect, all hex; expect is the read data, unused for write and flush
# op 0 read, 1 write, 2 flush, 3 read that must hit
0 00000100 f 00000000 5a5a5b5a
3 00000104 f 00000000 5a5a5b5e
3 00000100 f 00000000 5a5a5b5a
0 00000200 f 00000000 5a5a585a
1 00000200 1 ffffffa1 00000000
3 00000200 f 00000000 5a5a58a1
1 00000200 c b2c3ffff 00000000
3 00000200 f 00000000 b2c358a1
1 00000204 f 11223344 00000000
3 00000204 f 00000000 11223344
0 00000600 f 00000000 5a5a5c5a
0 00000200 f 00000000 b2c358a1
3 00000204 f 00000000 11223344
1 00000300 3 0000beef 00000000
1 00000108 f cafef00d 00000000
1 80000010 f deadbeef 00000000
0 80000010 f 00000000 deadbeef
1 80000010 6 00123400 00000000
0 80000010 3 00000000 000034ef
0 80000020 c 00000000 da5a0000
2 00000000 0 00000000 00000000
3 00000300 f 00000000 5a5abeef
3 00000108 f 00000000 cafef00d
3 00000200 f 00000000 b2c358a1
1 00000104 8 77000000 00000000
2 00000000 0 00000000 00000000
3 00000104 f 00000000 775a5b5e
